// ==== design/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// architectural registers with x0 reading as zero.
`define EXEC_NUM_REGS 16

// recent destination writes kept for operand forwarding.
`define EXEC_FWD_DEPTH 4

// data memory size in 32-bit words.
`define EXEC_DMEM_WORDS 64

`endif

// ==== design/exec_pkg.sv ====
`default_nettype none
`include "exec_config.svh"

package exec_pkg;

    typedef logic [$clog2(`EXEC_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_jal
    } op_kind_e;

    // compare ops share the encoding space with the arithmetic ops.
    typedef enum logic [3:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra,
        slt,
        sltu,
        beq,
        bne,
        blt
    } alu_op_e;

    typedef struct packed {
        logic [31:0] pc;
        op_kind_e    kind;
        alu_op_e     alu_op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [31:0] imm;
        logic        src2_is_imm;
        logic        writes_rd;
    } issue_s;

    typedef struct packed {
        op_kind_e    kind;
        reg_idx_t    rd;
        logic        writes_rd;
        logic [31:0] result;
        logic [31:0] store_data;
    } ex_mem_s;

    typedef struct packed {
        reg_idx_t    rd;
        logic [31:0] data;
    } wb_s;

endpackage

`default_nettype wire

// ==== design/exec_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_alu (
    input  exec_pkg::alu_op_e op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result,
    output logic              taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        // compare ops leave the sum on result for target use.
        result = a + b;
        taken  = 1'b0;
        case (op)
            exec_pkg::add:    result = a + b;
            exec_pkg::sub:    result = a - b;
            exec_pkg::and_op: result = a & b;
            exec_pkg::or_op:  result = a | b;
            exec_pkg::xor_op: result = a ^ b;
            exec_pkg::sll:    result = a << shamt;
            exec_pkg::srl:    result = a >> shamt;
            exec_pkg::sra:    result = $unsigned($signed(a) >>> shamt);
            exec_pkg::slt:    result = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::sltu:   result = {31'b0, a < b};
            exec_pkg::beq:    taken = (a == b);
            exec_pkg::bne:    taken = (a != b);
            exec_pkg::blt:    taken = ($signed(a) < $signed(b));
            default: begin
                result = a + b;
                taken  = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/exec_forward.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_config.svh"

module exec_forward (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  exec_pkg::reg_idx_t push_rd,
    input  logic [31:0]        push_data,
    input  logic               push_is_load,
    input  logic               load_done,
    input  logic [31:0]        load_data,
    input  exec_pkg::reg_idx_t rs1,
    input  exec_pkg::reg_idx_t rs2,
    input  logic [31:0]        rf_data1,
    input  logic [31:0]        rf_data2,
    output logic [31:0]        src1,
    output logic [31:0]        src2,
    output logic               src1_wait,
    output logic               src2_wait
);

    localparam int DEPTH = `EXEC_FWD_DEPTH;

    // entry 0 holds the newest write.
    logic [DEPTH-1:0]   ent_valid;
    logic [DEPTH-1:0]   ent_pend;
    exec_pkg::reg_idx_t ent_rd   [DEPTH];
    logic [31:0]        ent_data [DEPTH];

    logic [DEPTH-1:0]   fill_sel;
    logic [DEPTH-1:0]   pend_left;
    logic [31:0]        data_fill [DEPTH];

    // newest match wins, so walk from oldest to newest.
    function automatic logic [32:0] pick(input exec_pkg::reg_idx_t rs,
                                         input logic [31:0] rf_val);
        logic [32:0] res;
        res = {1'b0, rf_val};
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ent_valid[i] && ent_rd[i] == rs && rs != '0) begin
                res[31:0] = ent_data[i];
                res[32]   = res[32] | ent_pend[i];
            end
        end
        return res;
    endfunction

    always_comb begin
        {src1_wait, src1} = pick(rs1, rf_data1);
        {src2_wait, src2} = pick(rs2, rf_data2);
    end

    // loads return in order so the oldest pending entry gets the data.
    always_comb begin
        fill_sel = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ent_pend[i] && fill_sel == '0) begin
                fill_sel[i] = 1'b1;
            end
        end
        if (!load_done) begin
            fill_sel = '0;
        end
    end

    assign pend_left = ent_pend & ~fill_sel;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            data_fill[i] = fill_sel[i] ? load_data : ent_data[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
            ent_pend  <= '0;
        end else if (push) begin
            ent_valid <= {ent_valid[DEPTH-2:0], 1'b1};
            ent_pend  <= {pend_left[DEPTH-2:0], push_is_load};
        end else begin
            ent_pend <= pend_left;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ent_rd[0]   <= push_rd;
            ent_data[0] <= push_data;
            for (int i = 1; i < DEPTH; i++) begin
                ent_rd[i]   <= ent_rd[i-1];
                ent_data[i] <= data_fill[i-1];
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                ent_data[i] <= data_fill[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  exec_pkg::issue_s   issue,
    output logic               issue_ready,
    output exec_pkg::reg_idx_t rs1,
    output exec_pkg::reg_idx_t rs2,
    input  logic [31:0]        rf_data1,
    input  logic [31:0]        rf_data2,
    input  logic               mem_ready,
    input  logic               load_done,
    input  logic [31:0]        load_data,
    output logic               ex_valid,
    output exec_pkg::ex_mem_s  ex_out,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc,
    input  logic               pc_update
);

    logic [31:0]       src1;
    logic [31:0]       src2;
    logic              src1_wait;
    logic              src2_wait;
    logic [31:0]       alu_b;
    logic [31:0]       alu_result;
    logic              cmp_taken;
    logic [31:0]       target;
    logic [31:0]       link;
    logic [31:0]       result;
    logic              accept;
    logic              live;
    logic              transfer;
    logic              redirect_set;
    exec_pkg::ex_mem_s ex_next;

    assign rs1 = issue.rs1;
    assign rs2 = issue.rs2;

    assign issue_ready = mem_ready && !src1_wait && !src2_wait;
    assign accept      = issue_valid && issue_ready;
    // anything accepted behind a redirect is dropped.
    assign live        = accept && !redirect_valid;

    exec_forward forward_i (
        .clk          (clk),
        .rst          (rst),
        .push         (live && issue.writes_rd),
        .push_rd      (issue.rd),
        .push_data    (result),
        .push_is_load (issue.kind == exec_pkg::op_load),
        .load_done    (load_done),
        .load_data    (load_data),
        .rs1          (issue.rs1),
        .rs2          (issue.rs2),
        .rf_data1     (rf_data1),
        .rf_data2     (rf_data2),
        .src1         (src1),
        .src2         (src2),
        .src1_wait    (src1_wait),
        .src2_wait    (src2_wait)
    );

    assign alu_b = issue.src2_is_imm ? issue.imm : src2;

    exec_alu alu_i (
        .op     (issue.alu_op),
        .a      (src1),
        .b      (alu_b),
        .result (alu_result),
        .taken  (cmp_taken)
    );

    // branch and jal targets are pc relative.
    exec_alu target_i (
        .op     (exec_pkg::add),
        .a      (issue.pc),
        .b      (issue.imm),
        .result (target),
        .taken  ()
    );

    assign link     = issue.pc + 32'd4;
    assign result   = (issue.kind == exec_pkg::op_jal) ? link : alu_result;
    assign transfer = (issue.kind == exec_pkg::op_jal) ||
                      (issue.kind == exec_pkg::op_branch && cmp_taken);
    // a transfer to the fall-through pc needs no redirect.
    assign redirect_set = live && transfer && (target != link);

    always_comb begin
        ex_next.kind       = issue.kind;
        ex_next.rd         = issue.rd;
        ex_next.writes_rd  = issue.writes_rd;
        ex_next.result     = result;
        ex_next.store_data = src2;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            if (mem_ready) begin
                ex_valid <= live;
            end
            if (redirect_set) begin
                redirect_valid <= 1'b1;
            end else if (pc_update) begin
                redirect_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (live) begin
            ex_out <= ex_next;
        end
        if (redirect_set) begin
            redirect_pc <= target;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_config.svh"

module mem_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              ex_valid,
    input  exec_pkg::ex_mem_s ex_out,
    output logic              mem_ready,
    output logic              wb_valid,
    output exec_pkg::wb_s     wb,
    output logic              load_done,
    output logic [31:0]       load_data
);

    localparam int AW = $clog2(`EXEC_DMEM_WORDS);

    typedef enum logic {
        st_idle,
        st_read
    } state_e;

    state_e      state;
    logic [31:0] dmem [`EXEC_DMEM_WORDS];
    logic [AW-1:0] word_addr;
    logic [AW-1:0] ld_addr;
    logic          ld_writes;
    logic          take;

    assign word_addr = ex_out.result[AW+1:2];
    assign mem_ready = (state == st_idle);
    assign take      = ex_valid && mem_ready;
    // load data leaves through the writeback register.
    assign load_data = wb.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            wb_valid  <= 1'b0;
            load_done <= 1'b0;
            ld_writes <= 1'b0;
        end else begin
            wb_valid  <= 1'b0;
            load_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (take && ex_out.kind == exec_pkg::op_load) begin
                        state     <= st_read;
                        ld_writes <= ex_out.writes_rd;
                    end else if (take) begin
                        wb_valid <= ex_out.writes_rd;
                    end
                end
                st_read: begin
                    state     <= st_idle;
                    wb_valid  <= ld_writes;
                    load_done <= ld_writes;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (ex_out.kind == exec_pkg::op_store) begin
                dmem[word_addr] <= ex_out.store_data;
            end
            wb.rd   <= ex_out.rd;
            wb.data <= ex_out.result;
            ld_addr <= word_addr;
        end
        if (state == st_read) begin
            wb.data <= dmem[ld_addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_config.svh"

module exec_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  exec_pkg::issue_s issue,
    output logic             issue_ready,
    output logic             redirect_valid,
    output logic [31:0]      redirect_pc,
    input  logic             pc_update,
    output logic             wb_valid,
    output exec_pkg::wb_s    wb
);

    logic [31:0]        regs [`EXEC_NUM_REGS];
    exec_pkg::reg_idx_t rs1;
    exec_pkg::reg_idx_t rs2;
    logic [31:0]        rf_data1;
    logic [31:0]        rf_data2;
    logic               mem_ready;
    logic               ex_valid;
    exec_pkg::ex_mem_s  ex_out;
    logic               load_done;
    logic [31:0]        load_data;

    // x0 is never written and always reads zero.
    always_ff @(posedge clk) begin
        if (wb_valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rf_data1 = (rs1 == '0) ? 32'd0 : regs[rs1];
    assign rf_data2 = (rs2 == '0) ? 32'd0 : regs[rs2];

    exec_unit exec_unit_i (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .rs1            (rs1),
        .rs2            (rs2),
        .rf_data1       (rf_data1),
        .rf_data2       (rf_data2),
        .mem_ready      (mem_ready),
        .load_done      (load_done),
        .load_data      (load_data),
        .ex_valid       (ex_valid),
        .ex_out         (ex_out),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc_update      (pc_update)
    );

    mem_stage mem_stage_i (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .ex_out    (ex_out),
        .mem_ready (mem_ready),
        .wb_valid  (wb_valid),
        .wb        (wb),
        .load_done (load_done),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

// ==== sim/exec_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
    end

    always begin
        #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== sim/exec_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_assertions (
    input logic              clk,
    input logic              rst,
    input logic              issue_valid,
    input logic              mem_ready,
    input logic              ex_valid,
    input exec_pkg::ex_mem_s ex_out,
    input logic              redirect_valid,
    input logic              pc_update,
    input logic              src1_wait,
    input logic              src2_wait
);

    redirect_hold: assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !pc_update |=> redirect_valid)
        else $error("redirect_valid dropped without a pc_update pulse");

    // memory stall must freeze the execute output.
    ex_out_stable: assert property (@(posedge clk) disable iff (rst)
        ex_valid && !mem_ready |=> $stable(ex_out))
        else $error("ex_out changed while the memory stage was stalled");

    // a waiting instruction must not reach the memory stage.
    no_accept_on_wait: assert property (@(posedge clk) disable iff (rst)
        (src1_wait || src2_wait) && issue_valid && mem_ready |=> !ex_valid)
        else $error("instruction accepted while an operand waited on a load");

endmodule

bind exec_unit exec_assertions assertions_i (
    .clk            (clk),
    .rst            (rst),
    .issue_valid    (issue_valid),
    .mem_ready      (mem_ready),
    .ex_valid       (ex_valid),
    .ex_out         (ex_out),
    .redirect_valid (redirect_valid),
    .pc_update      (pc_update),
    .src1_wait      (src1_wait),
    .src2_wait      (src2_wait)
);

`default_nettype wire

// ==== sim/exec_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_config.svh"

module exec_tb;

    localparam int TIMEOUT = 50;

    logic             clk;
    logic             rst;
    logic             issue_valid;
    exec_pkg::issue_s issue;
    logic             issue_ready;
    logic             redirect_valid;
    logic [31:0]      redirect_pc;
    logic             pc_update;
    logic             wb_valid;
    exec_pkg::wb_s    wb;

    integer           seed;
    logic [31:0]      model_regs [`EXEC_NUM_REGS];
    logic [31:0]      model_mem [`EXEC_DMEM_WORDS];
    exec_pkg::wb_s    wb_q [$];
    logic [31:0]      redir_q [$];
    logic             shadow;
    int               shadow_cnt;
    logic [31:0]      pc;
    logic             redir_seen;

    exec_clock clock_i (
        .clk (clk)
    );

    exec_top exec_top_i (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc_update      (pc_update),
        .wb_valid       (wb_valid),
        .wb             (wb)
    );

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] alu_model(input exec_pkg::alu_op_e op,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        case (op)
            exec_pkg::sub:    r = a - b;
            exec_pkg::and_op: r = a & b;
            exec_pkg::or_op:  r = a | b;
            exec_pkg::xor_op: r = a ^ b;
            exec_pkg::sll:    r = a << b[4:0];
            exec_pkg::srl:    r = a >> b[4:0];
            exec_pkg::sra:    r = $signed(a) >>> b[4:0];
            exec_pkg::slt:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::sltu:   r = (a < b) ? 32'd1 : 32'd0;
            default:          r = a + b;
        endcase
        return r;
    endfunction

    // returns 1 when the instruction redirects fetch.
    function automatic logic model_instr(input exec_pkg::issue_s ins);
        logic [31:0]   a;
        logic [31:0]   b2;
        logic [31:0]   r;
        logic          taken;
        exec_pkg::wb_s w;
        a     = (ins.rs1 == 0) ? 32'd0 : model_regs[ins.rs1];
        b2    = (ins.rs2 == 0) ? 32'd0 : model_regs[ins.rs2];
        r     = alu_model(ins.alu_op, a, ins.src2_is_imm ? ins.imm : b2);
        taken = 1'b0;
        case (ins.kind)
            exec_pkg::op_load:  r = model_mem[r[7:2]];
            exec_pkg::op_store: model_mem[r[7:2]] = b2;
            exec_pkg::op_jal: begin
                r     = ins.pc + 32'd4;
                taken = 1'b1;
            end
            exec_pkg::op_branch: begin
                taken = (ins.alu_op == exec_pkg::beq && a == b2) ||
                        (ins.alu_op == exec_pkg::bne && a != b2) ||
                        (ins.alu_op == exec_pkg::blt && $signed(a) < $signed(b2));
            end
            default: taken = 1'b0;
        endcase
        if (ins.writes_rd) begin
            w.rd   = ins.rd;
            w.data = r;
            wb_q.push_back(w);
            if (ins.rd != 0) begin
                model_regs[ins.rd] = r;
            end
        end
        if (taken && (ins.pc + ins.imm) != (ins.pc + 32'd4)) begin
            redir_q.push_back(ins.pc + ins.imm);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic exec_pkg::issue_s build_instr(input exec_pkg::op_kind_e kind,
                                                     input exec_pkg::alu_op_e op,
                                                     input int rd,
                                                     input int rs1,
                                                     input int rs2,
                                                     input logic [31:0] imm,
                                                     input int use_imm);
        exec_pkg::issue_s ins;
        ins.pc          = pc;
        ins.kind        = kind;
        ins.alu_op      = op;
        ins.rd          = exec_pkg::reg_idx_t'(rd);
        ins.rs1         = exec_pkg::reg_idx_t'(rs1);
        ins.rs2         = exec_pkg::reg_idx_t'(rs2);
        ins.imm         = imm;
        ins.src2_is_imm = (use_imm != 0);
        ins.writes_rd   = (kind == exec_pkg::op_alu) || (kind == exec_pkg::op_load) ||
                          (kind == exec_pkg::op_jal);
        return ins;
    endfunction

    // loads and stores stay inside the eight words written up front.
    function automatic exec_pkg::issue_s random_instr();
        int sel;
        sel = rnd(10);
        if (sel < 6) begin
            return build_instr(exec_pkg::op_alu, exec_pkg::alu_op_e'(rnd(10)), rnd(16),
                               rnd(16), rnd(16), $random(seed), rnd(2));
        end else if (sel == 6) begin
            return build_instr(exec_pkg::op_load, exec_pkg::add, rnd(16), 0, rnd(16),
                               rnd(8) * 4, 1);
        end else if (sel == 7) begin
            return build_instr(exec_pkg::op_store, exec_pkg::add, 0, 0, rnd(16),
                               rnd(8) * 4, 1);
        end else if (sel == 8) begin
            return build_instr(exec_pkg::op_branch, exec_pkg::alu_op_e'(10 + rnd(3)), 0,
                               rnd(16), rnd(16), (rnd(4) + 1) * 4, 0);
        end
        return build_instr(exec_pkg::op_jal, exec_pkg::add, rnd(16), 0, 0,
                           (rnd(4) + 1) * 4, 0);
    endfunction

    task automatic pulse_pc_update();
        pc_update = 1'b1;
        @(posedge clk);
        #1;
        pc_update  = 1'b0;
        shadow     = 1'b0;
        shadow_cnt = 0;
    endtask

    // two instructions go into the redirect shadow before fetch catches up.
    task automatic issue_one(input exec_pkg::issue_s ins, output int stalls);
        logic ok;
        issue       = ins;
        issue_valid = 1'b1;
        stalls      = 0;
        ok          = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = issue_ready;
            @(posedge clk);
            #1;
            if (!ok) begin
                stalls++;
                if (stalls > TIMEOUT) begin
                    $display("timeout, issue_ready stayed low for %0d cycles", stalls);
                    stop_run();
                end
            end
        end
        issue_valid = 1'b0;
        pc          = pc + 32'd4;
        if (shadow) begin
            shadow_cnt++;
            if (shadow_cnt == 2) begin
                pulse_pc_update();
            end
        end else if (model_instr(ins)) begin
            shadow     = 1'b1;
            shadow_cnt = 0;
            pc         = ins.pc + ins.imm;
        end
    endtask

    always @(negedge clk) begin : compare
        exec_pkg::wb_s exp;
        logic [31:0]   exp_pc;
        if (!rst) begin
            if (wb_valid) begin
                assert (wb_q.size() > 0) else begin
                    $display("unexpected writeback to x%0d at time %0t", wb.rd, $time);
                    stop_run();
                end
                exp = wb_q.pop_front();
                assert (wb === exp) else begin
                    $display("[FAIL] %0t: writeback x%0d=%h, expected x%0d=%h",
                             $time, wb.rd, wb.data, exp.rd, exp.data);
                    stop_run();
                end
            end
            if (redirect_valid && !redir_seen) begin
                assert (redir_q.size() > 0) else begin
                    $display("unexpected redirect to %h at time %0t", redirect_pc, $time);
                    stop_run();
                end
                exp_pc = redir_q.pop_front();
                assert (redirect_pc === exp_pc) else begin
                    $display("[FAIL] %0t: redirect_pc=%h, expected %h",
                             $time, redirect_pc, exp_pc);
                    stop_run();
                end
            end
            redir_seen = redirect_valid;
        end
    end

    initial begin
        int stalls;
        int waited;
        seed        = 32'h006be8a1;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        pc_update   = 1'b0;
        shadow      = 1'b0;
        shadow_cnt  = 0;
        pc          = 32'h0000_0100;
        redir_seen  = 1'b0;
        for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // every register gets a value, then ops on independent registers.
        for (int i = 1; i < `EXEC_NUM_REGS; i++) begin
            issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, i, 0, 0,
                                  $random(seed), 1), stalls);
        end
        for (int k = 0; k < 10; k++) begin
            issue_one(build_instr(exec_pkg::op_alu, exec_pkg::alu_op_e'(k), 11 + k % 5,
                                  1 + k % 5, 6 + k % 5, 32'd0, 0), stalls);
        end

        // dependent chain at distances 1 to 3.
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 3, 1, 2, 0, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::sub, 4, 3, 1, 0, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::xor_op, 5, 4, 3, 0, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::or_op, 6, 5, 3, 0, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::sra, 7, 6, 0, 3, 1), stalls);

        // fill data words 0 to 7, then a load with an immediate consumer.
        for (int w = 0; w < 8; w++) begin
            issue_one(build_instr(exec_pkg::op_store, exec_pkg::add, 0, 0, 1 + w, w * 4, 1),
                      stalls);
        end
        issue_one(build_instr(exec_pkg::op_load, exec_pkg::add, 8, 0, 0, 12, 1), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 9, 8, 1, 0, 0), stalls);
        assert (stalls > 0) else begin
            $display("load consumer was accepted without waiting for the load");
            stop_run();
        end

        // x0 writes are dropped and x0 reads as zero.
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 0, 1, 0, 5, 1), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 10, 0, 0, 0, 0), stalls);

        // taken branch, jal with link, then a branch that falls through.
        issue_one(build_instr(exec_pkg::op_branch, exec_pkg::beq, 0, 1, 1, 16, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 2, 1, 1, 0, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 3, 1, 1, 0, 0), stalls);
        issue_one(build_instr(exec_pkg::op_jal, exec_pkg::add, 11, 0, 0, 64, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 11, 1, 1, 0, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 12, 1, 1, 0, 0), stalls);
        issue_one(build_instr(exec_pkg::op_branch, exec_pkg::bne, 0, 1, 1, 16, 0), stalls);
        issue_one(build_instr(exec_pkg::op_alu, exec_pkg::add, 12, 11, 0, 0, 0), stalls);

        for (int n = 0; n < 200; n++) begin
            issue_one(random_instr(), stalls);
        end
        if (shadow) begin
            pulse_pc_update();
        end

        waited = 0;
        while ((wb_q.size() > 0 || redir_q.size() > 0) && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);
        if (wb_q.size() == 0 && redir_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("timeout, %0d writebacks and %0d redirects never arrived",
                     wb_q.size(), redir_q.size());
            stop_run();
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/exec_pkg.sv
design/exec_alu.sv
design/exec_forward.sv
design/exec_unit.sv
design/mem_stage.sv
design/exec_top.sv
sim/exec_clock.sv
sim/exec_assertions.sv
sim/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module exec_tb -f compile.f -o exec_sim \
    && ./obj_dir/exec_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
